// File: source/mips_exec_pkg.sv
`default_nettype none

package mips_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] imm_t;

  // Decoded fields of one issued instruction
  typedef struct packed {
    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rt_idx;    // REGIMM selector
    reg_idx_t shamt;
    imm_t     imm;
  } exec_instr_t;

  localparam opcode_t op_special = 6'h00;
  localparam opcode_t op_regimm  = 6'h01;
  localparam opcode_t op_beq     = 6'h04;
  localparam opcode_t op_bne     = 6'h05;
  localparam opcode_t op_addiu   = 6'h09;
  localparam opcode_t op_slti    = 6'h0a;
  localparam opcode_t op_sltiu   = 6'h0b;
  localparam opcode_t op_andi    = 6'h0c;
  localparam opcode_t op_ori     = 6'h0d;
  localparam opcode_t op_xori    = 6'h0e;
  localparam opcode_t op_lui     = 6'h0f;
  localparam opcode_t op_lb      = 6'h20;
  localparam opcode_t op_lh      = 6'h21;
  localparam opcode_t op_lw      = 6'h23;
  localparam opcode_t op_lbu     = 6'h24;
  localparam opcode_t op_lhu     = 6'h25;
  localparam opcode_t op_sb      = 6'h28;
  localparam opcode_t op_sh      = 6'h29;
  localparam opcode_t op_sw      = 6'h2b;

  localparam funct_t fn_sll   = 6'h00;
  localparam funct_t fn_srl   = 6'h02;
  localparam funct_t fn_sra   = 6'h03;
  localparam funct_t fn_sllv  = 6'h04;
  localparam funct_t fn_srlv  = 6'h06;
  localparam funct_t fn_srav  = 6'h07;
  localparam funct_t fn_mfhi  = 6'h10;
  localparam funct_t fn_mflo  = 6'h12;
  localparam funct_t fn_mult  = 6'h18;
  localparam funct_t fn_multu = 6'h19;
  localparam funct_t fn_div   = 6'h1a;
  localparam funct_t fn_divu  = 6'h1b;
  localparam funct_t fn_addu  = 6'h21;
  localparam funct_t fn_subu  = 6'h23;
  localparam funct_t fn_and   = 6'h24;
  localparam funct_t fn_or    = 6'h25;
  localparam funct_t fn_xor   = 6'h26;
  localparam funct_t fn_nor   = 6'h27;
  localparam funct_t fn_slt   = 6'h2a;
  localparam funct_t fn_sltu  = 6'h2b;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_sll,
    alu_srl, alu_sra, alu_slt, alu_sltu, alu_lui, alu_pass
  } alu_op_e;

  // Operand a uses rs, hi, lo and operand b uses rt, sign-ext imm, zero-ext imm
  typedef enum logic [1:0] {
    sel_reg     = 2'd0,
    sel_hi_sext = 2'd1,
    sel_lo_zext = 2'd2
  } operand_sel_e;

  typedef struct packed {
    alu_op_e      op;
    operand_sel_e a_sel;
    operand_sel_e b_sel;
    logic         shift_var;  // Shift by rs instead of shamt
  } alu_ctrl_t;

  typedef enum logic [2:0] {br_none, br_eq, br_ne, br_ltz, br_gez} branch_kind_e;

  typedef enum logic [2:0] {md_none, md_mult, md_multu, md_div, md_divu} md_op_e;

endpackage

`default_nettype wire

// File: source/exec_control.sv
`timescale 1ns/1ns
`default_nettype none

module exec_control (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         issue,
  input  wire mips_exec_pkg::exec_instr_t instr,
  input  wire                         div_active,
  output logic                        alu_load,
  output logic                        branch_load,
  output logic                        md_start,
  output mips_exec_pkg::alu_ctrl_t    alu_ctrl,
  output mips_exec_pkg::branch_kind_e branch_kind,
  output mips_exec_pkg::md_op_e       md_op,
  output logic                        busy
);

  import mips_exec_pkg::*;

  typedef enum logic {st_idle, st_dividing} state_e;

  state_e state;
  logic   accept;
  logic   is_alu;
  logic   is_branch;
  logic   is_md;
  logic   div_start;

  assign busy   = (state == st_dividing) && div_active;
  assign accept = issue && !busy;  // Issues during a divide are dropped

  always_comb
  begin
    alu_ctrl.op        = alu_pass;
    alu_ctrl.a_sel     = sel_reg;
    alu_ctrl.b_sel     = sel_reg;
    alu_ctrl.shift_var = 1'b0;
    branch_kind = br_none;
    md_op       = md_none;
    is_alu      = 1'b0;
    is_branch   = 1'b0;
    is_md       = 1'b0;
    case (instr.opcode)
      op_special:
      begin
        is_alu = 1'b1;  // Cleared below for mult/div and unknown functs
        case (instr.funct)
          fn_addu: alu_ctrl.op = alu_add;
          fn_subu: alu_ctrl.op = alu_sub;
          fn_and:  alu_ctrl.op = alu_and;
          fn_or:   alu_ctrl.op = alu_or;
          fn_xor:  alu_ctrl.op = alu_xor;
          fn_nor:  alu_ctrl.op = alu_nor;
          fn_slt:  alu_ctrl.op = alu_slt;
          fn_sltu: alu_ctrl.op = alu_sltu;
          fn_sll:  alu_ctrl.op = alu_sll;
          fn_srl:  alu_ctrl.op = alu_srl;
          fn_sra:  alu_ctrl.op = alu_sra;
          fn_sllv:
          begin
            alu_ctrl.op        = alu_sll;
            alu_ctrl.shift_var = 1'b1;
          end
          fn_srlv:
          begin
            alu_ctrl.op        = alu_srl;
            alu_ctrl.shift_var = 1'b1;
          end
          fn_srav:
          begin
            alu_ctrl.op        = alu_sra;
            alu_ctrl.shift_var = 1'b1;
          end
          fn_mfhi: alu_ctrl.a_sel = sel_hi_sext;  // Pass hi through
          fn_mflo: alu_ctrl.a_sel = sel_lo_zext;  // Pass lo through
          fn_mult, fn_multu, fn_div, fn_divu:
          begin
            is_alu = 1'b0;
            is_md  = 1'b1;
            case (instr.funct)
              fn_mult:  md_op = md_mult;
              fn_multu: md_op = md_multu;
              fn_div:   md_op = md_div;
              default:  md_op = md_divu;
            endcase
          end
          default: is_alu = 1'b0;
        endcase
      end
      op_regimm:
      begin
        is_branch = 1'b1;
        case (instr.rt_idx)
          5'd0, 5'd16: branch_kind = br_ltz;  // BLTZ, BLTZAL
          5'd1, 5'd17: branch_kind = br_gez;  // BGEZ, BGEZAL
          default:     is_branch = 1'b0;
        endcase
      end
      op_beq:
      begin
        is_branch   = 1'b1;
        branch_kind = br_eq;
      end
      op_bne:
      begin
        is_branch   = 1'b1;
        branch_kind = br_ne;
      end
      op_addiu, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw:
      begin
        is_alu         = 1'b1;  // Effective address for loads and stores
        alu_ctrl.op    = alu_add;
        alu_ctrl.b_sel = sel_hi_sext;
      end
      op_slti, op_sltiu:
      begin
        is_alu         = 1'b1;
        alu_ctrl.op    = (instr.opcode == op_slti) ? alu_slt : alu_sltu;
        alu_ctrl.b_sel = sel_hi_sext;  // SLTIU also sign-extends
      end
      op_andi, op_ori, op_xori:
      begin
        is_alu         = 1'b1;
        alu_ctrl.b_sel = sel_lo_zext;
        case (instr.opcode)
          op_andi: alu_ctrl.op = alu_and;
          op_ori:  alu_ctrl.op = alu_or;
          default: alu_ctrl.op = alu_xor;
        endcase
      end
      op_lui:
      begin
        is_alu      = 1'b1;
        alu_ctrl.op = alu_lui;
      end
      default: ;  // Unknown opcode, no strobe
    endcase
  end

  assign alu_load    = accept && is_alu;
  assign branch_load = accept && is_branch;
  assign md_start    = accept && is_md;
  assign div_start   = md_start && (md_op == md_div || md_op == md_divu);

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle:
          if (div_start)
            state <= st_dividing;
        st_dividing:
          if (!div_start && !div_active)
            state <= st_idle;  // Divider has written hi and lo
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      load,
  input  wire mips_exec_pkg::alu_ctrl_t ctrl,
  input  wire mips_exec_pkg::word_t    rs_value,
  input  wire mips_exec_pkg::word_t    rt_value,
  input  wire mips_exec_pkg::word_t    hi,
  input  wire mips_exec_pkg::word_t    lo,
  input  wire mips_exec_pkg::imm_t     imm,
  input  wire mips_exec_pkg::reg_idx_t shamt,
  output mips_exec_pkg::word_t     result,
  output logic                     result_valid
);

  import mips_exec_pkg::*;

  word_t    imm_sext;
  word_t    imm_zext;
  word_t    operand_a;
  word_t    operand_b;
  reg_idx_t shift_amt;
  word_t    alu_out;

  assign imm_sext  = {{16{imm[15]}}, imm};
  assign imm_zext  = {16'h0000, imm};
  assign shift_amt = ctrl.shift_var ? rs_value[4:0] : shamt;  // Low 5 bits of rs

  always_comb
  begin
    case (ctrl.a_sel)
      sel_hi_sext: operand_a = hi;
      sel_lo_zext: operand_a = lo;
      default:     operand_a = rs_value;
    endcase
    case (ctrl.b_sel)
      sel_hi_sext: operand_b = imm_sext;
      sel_lo_zext: operand_b = imm_zext;
      default:     operand_b = rt_value;
    endcase
  end

  always_comb
  begin
    case (ctrl.op)
      alu_add:  alu_out = operand_a + operand_b;
      alu_sub:  alu_out = operand_a - operand_b;
      alu_and:  alu_out = operand_a & operand_b;
      alu_or:   alu_out = operand_a | operand_b;
      alu_xor:  alu_out = operand_a ^ operand_b;
      alu_nor:  alu_out = ~(operand_a | operand_b);
      alu_sll:  alu_out = operand_b << shift_amt;  // Shifts act on rt
      alu_srl:  alu_out = operand_b >> shift_amt;
      alu_sra:  alu_out = $signed(operand_b) >>> shift_amt;
      alu_slt:  alu_out = {31'b0, $signed(operand_a) < $signed(operand_b)};
      alu_sltu: alu_out = {31'b0, operand_a < operand_b};
      alu_lui:  alu_out = {imm, 16'h0000};
      default:  alu_out = operand_a;  // Pass, used by MFHI and MFLO
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result       <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= load;
      if (load)
        result <= alu_out;
    end
  end

endmodule

`default_nettype wire

// File: source/branch_compare.sv
`timescale 1ns/1ns
`default_nettype none

module branch_compare (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          load,
  input  wire mips_exec_pkg::branch_kind_e kind,
  input  wire mips_exec_pkg::word_t        rs_value,
  input  wire mips_exec_pkg::word_t        rt_value,
  output logic                         branch_valid,
  output logic                         branch_taken
);

  import mips_exec_pkg::*;

  logic taken_next;

  always_comb
  begin
    case (kind)
      br_eq:   taken_next = (rs_value == rt_value);
      br_ne:   taken_next = (rs_value != rt_value);
      br_ltz:  taken_next = rs_value[31];  // Sign bit only
      br_gez:  taken_next = !rs_value[31];
      default: taken_next = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      branch_valid <= 1'b0;
      branch_taken <= 1'b0;
    end
    else
    begin
      branch_valid <= load;
      if (load)
        branch_taken <= taken_next;  // Held until the next branch
    end
  end

endmodule

`default_nettype wire

// File: source/mul_div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_div_unit (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    start,
  input  wire mips_exec_pkg::md_op_e op,
  input  wire mips_exec_pkg::word_t  rs_value,
  input  wire mips_exec_pkg::word_t  rt_value,
  output logic                   div_active,
  output mips_exec_pkg::word_t   hi,
  output mips_exec_pkg::word_t   lo
);

  import mips_exec_pkg::*;

  localparam logic [5:0] div_steps = 6'd32;

  logic               is_signed;
  logic               mul_go;
  logic               div_go;
  logic signed [32:0] mul_a;
  logic signed [32:0] mul_b;
  logic signed [65:0] product;
  word_t              rs_mag;
  word_t              rt_mag;
  word_t              quot;
  word_t              rem;
  word_t              divisor;
  logic [32:0]        shifted;
  logic [32:0]        diff;
  logic               q_neg;
  logic               r_neg;
  logic [5:0]         step;

  assign is_signed = (op == md_mult) || (op == md_div);
  assign mul_go    = start && (op == md_mult || op == md_multu);
  assign div_go    = start && (op == md_div || op == md_divu);

  // 33-bit operands cover both signed and unsigned products
  assign mul_a   = {is_signed & rs_value[31], rs_value};
  assign mul_b   = {is_signed & rt_value[31], rt_value};
  assign product = mul_a * mul_b;

  assign rs_mag = (is_signed && rs_value[31]) ? -rs_value : rs_value;
  assign rt_mag = (is_signed && rt_value[31]) ? -rt_value : rt_value;

  assign shifted = {rem, quot[31]};  // Partial remainder with next dividend bit
  assign diff    = shifted - {1'b0, divisor};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi         <= '0;
      lo         <= '0;
      div_active <= 1'b0;
      step       <= '0;
    end
    else if (mul_go)
    begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
    else if (div_go)
    begin
      div_active <= 1'b1;
      step       <= '0;
    end
    else if (div_active && step == div_steps)
    begin
      hi         <= r_neg ? -rem : rem;  // Sign fix step
      lo         <= q_neg ? -quot : quot;
      div_active <= 1'b0;
    end
    else if (div_active)
      step <= step + 6'd1;
  end

  // Restoring divider datapath
  always_ff @(posedge clk)
  begin
    if (div_go)
    begin
      quot    <= rs_mag;
      rem     <= '0;
      divisor <= rt_mag;
      q_neg   <= is_signed && (rs_value[31] ^ rt_value[31]);
      r_neg   <= is_signed && rs_value[31];
    end
    else if (div_active && step < div_steps)
    begin
      if (shifted >= {1'b0, divisor})
      begin
        rem  <= diff[31:0];
        quot <= {quot[30:0], 1'b1};
      end
      else
      begin
        rem  <= shifted[31:0];
        quot <= {quot[30:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mips_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module mips_exec_top (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         issue,
  input  wire mips_exec_pkg::exec_instr_t instr,
  input  wire mips_exec_pkg::word_t       rs_value,
  input  wire mips_exec_pkg::word_t       rt_value,
  output mips_exec_pkg::word_t        result,
  output logic                        result_valid,
  output logic                        branch_valid,
  output logic                        branch_taken,
  output mips_exec_pkg::word_t        hi,
  output mips_exec_pkg::word_t        lo,
  output logic                        busy
);

  import mips_exec_pkg::*;

  logic         alu_load;
  logic         branch_load;
  logic         md_start;
  logic         div_active;
  alu_ctrl_t    alu_ctrl;
  branch_kind_e branch_kind;
  md_op_e       md_op;

  exec_control u_control (
    .clk         (clk),
    .reset       (reset),
    .issue       (issue),
    .instr       (instr),
    .div_active  (div_active),
    .alu_load    (alu_load),
    .branch_load (branch_load),
    .md_start    (md_start),
    .alu_ctrl    (alu_ctrl),
    .branch_kind (branch_kind),
    .md_op       (md_op),
    .busy        (busy)
  );

  mips_alu u_alu (
    .clk          (clk),
    .reset        (reset),
    .load         (alu_load),
    .ctrl         (alu_ctrl),
    .rs_value     (rs_value),
    .rt_value     (rt_value),
    .hi           (hi),  // MFHI and MFLO source
    .lo           (lo),
    .imm          (instr.imm),
    .shamt        (instr.shamt),
    .result       (result),
    .result_valid (result_valid)
  );

  branch_compare u_branch (
    .clk          (clk),
    .reset        (reset),
    .load         (branch_load),
    .kind         (branch_kind),
    .rs_value     (rs_value),
    .rt_value     (rt_value),
    .branch_valid (branch_valid),
    .branch_taken (branch_taken)
  );

  mul_div_unit u_mul_div (
    .clk        (clk),
    .reset      (reset),
    .start      (md_start),
    .op         (md_op),
    .rs_value   (rs_value),
    .rt_value   (rt_value),
    .div_active (div_active),
    .hi         (hi),
    .lo         (lo)
  );

endmodule

`default_nettype wire

// File: sim/mips_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_exec_tb;

  import mips_exec_pkg::*;

  localparam int clk_period  = 100;
  localparam int num_rtype   = 40;
  localparam int num_itype   = 40;
  localparam int num_branch  = 32;
  localparam int num_mul     = 12;  // Operand pairs, each run as MULT and MULTU
  localparam int num_div     = 11;  // Operand pairs, each run as DIV and DIVU
  localparam int total_ops   = num_rtype + num_itype + num_branch + num_mul * 6 + num_div * 4;
  localparam int limit_ticks = (total_ops * 40 + 200) * clk_period;

  localparam logic [1:0] kind_none   = 2'd0;
  localparam logic [1:0] kind_result = 2'd1;
  localparam logic [1:0] kind_branch = 2'd2;
  localparam logic [1:0] kind_div    = 2'd3;

  logic        clk;
  logic        reset;
  logic        issue;
  exec_instr_t instr;
  word_t       rs_value;
  word_t       rt_value;
  word_t       result;
  logic        result_valid;
  logic        branch_valid;
  logic        branch_taken;
  word_t       hi;
  word_t       lo;
  logic        busy;

  logic [1:0]  expect_kind;  // What the current issue should produce
  logic        rv_due;
  logic        br_due;
  logic        div_due;
  int          busy_run;
  word_t       rng_state;
  word_t       model_hi;
  word_t       model_lo;
  string       test_name;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  funct_t      rtype_fn [14];
  opcode_t     itype_op [15];

  mips_exec_top UUT (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .instr        (instr),
    .rs_value     (rs_value),
    .rt_value     (rt_value),
    .result       (result),
    .result_valid (result_valid),
    .branch_valid (branch_valid),
    .branch_taken (branch_taken),
    .hi           (hi),
    .lo           (lo),
    .busy         (busy)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Mostly random values with frequent sign boundary cases
  function automatic word_t pick_operand();
    word_t r;
    word_t v;
    r = next_rand();
    case (r[2:0])
      3'd0:    v = 32'h8000_0000;
      3'd1:    v = 32'h7fff_ffff;
      3'd2:    v = 32'hffff_ffff;
      3'd3:    v = 32'h0000_0000;
      default: v = next_rand();
    endcase
    return v;
  endfunction

  function automatic exec_instr_t make_r(input funct_t fn, input reg_idx_t sh);
    exec_instr_t ins;
    ins        = '0;
    ins.opcode = op_special;
    ins.funct  = fn;
    ins.shamt  = sh;
    return ins;
  endfunction

  function automatic exec_instr_t make_i(input opcode_t op, input imm_t imm);
    exec_instr_t ins;
    ins        = '0;
    ins.opcode = op;
    ins.imm    = imm;
    return ins;
  endfunction

  // Expected ALU result from the MIPS instruction definitions
  function automatic word_t model_alu(input exec_instr_t ins, input word_t rs, input word_t rt);
    word_t sext;
    word_t zext;
    word_t res;
    sext = {{16{ins.imm[15]}}, ins.imm};
    zext = {16'h0000, ins.imm};
    res  = '0;
    case (ins.opcode)
      op_special:
        case (ins.funct)
          fn_addu: res = rs + rt;
          fn_subu: res = rs - rt;
          fn_and:  res = rs & rt;
          fn_or:   res = rs | rt;
          fn_xor:  res = rs ^ rt;
          fn_nor:  res = ~(rs | rt);
          fn_sll:  res = rt << ins.shamt;
          fn_srl:  res = rt >> ins.shamt;
          fn_sra:  res = $signed(rt) >>> ins.shamt;
          fn_sllv: res = rt << rs[4:0];
          fn_srlv: res = rt >> rs[4:0];
          fn_srav: res = $signed(rt) >>> rs[4:0];
          fn_slt:  res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
          fn_sltu: res = (rs < rt) ? 32'd1 : 32'd0;
          fn_mfhi: res = model_hi;
          fn_mflo: res = model_lo;
          default: res = '0;
        endcase
      op_addiu, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw:
        res = rs + sext;
      op_slti:  res = ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
      op_sltiu: res = (rs < sext) ? 32'd1 : 32'd0;
      op_andi:  res = rs & zext;
      op_ori:   res = rs | zext;
      op_xori:  res = rs ^ zext;
      op_lui:   res = {ins.imm, 16'h0000};
      default:  res = '0;
    endcase
    return res;
  endfunction

  function automatic logic model_branch(input exec_instr_t ins, input word_t rs, input word_t rt);
    logic taken;
    taken = 1'b0;
    if (ins.opcode == op_beq)
      taken = (rs == rt);
    else if (ins.opcode == op_bne)
      taken = (rs != rt);
    else if (ins.rt_idx == 5'd0 || ins.rt_idx == 5'd16)
      taken = rs[31];  // BLTZ, BLTZAL
    else if (ins.rt_idx == 5'd1 || ins.rt_idx == 5'd17)
      taken = !rs[31];  // BGEZ, BGEZAL
    return taken;
  endfunction

  task automatic model_mul(input logic signed_op, input word_t rs, input word_t rt);
    logic signed [63:0] a;
    logic signed [63:0] b;
    logic [63:0]        p;
    if (signed_op)
    begin
      a = $signed(rs);
      b = $signed(rt);
    end
    else
    begin
      a = {32'h0, rs};
      b = {32'h0, rt};
    end
    p        = a * b;
    model_hi = p[63:32];
    model_lo = p[31:0];
  endtask

  // Quotient takes the sign of rs xor rt and the remainder that of rs
  // A zero divisor gives an all ones quotient magnitude
  task automatic model_div(input logic signed_op, input word_t rs, input word_t rt);
    word_t rs_abs;
    word_t rt_abs;
    word_t q;
    word_t r;
    rs_abs = (signed_op && rs[31]) ? -rs : rs;
    rt_abs = (signed_op && rt[31]) ? -rt : rt;
    if (rt_abs == 0)
    begin
      q = '1;
      r = rs_abs;
    end
    else
    begin
      q = rs_abs / rt_abs;
      r = rs_abs % rt_abs;
    end
    if (signed_op && (rs[31] ^ rt[31]))
      q = -q;
    if (signed_op && rs[31])
      r = -r;
    model_hi = r;
    model_lo = q;
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("%-14s %0d checks, %0d errors", test_name, checks - test_checks,
             errors - test_errors);
  endtask

  // Drive one issue cycle and return 5 ns after the edge that samples it
  task automatic issue_op(input exec_instr_t ins, input word_t rs, input word_t rt,
                          input logic [1:0] kind);
    instr       = ins;
    rs_value    = rs;
    rt_value    = rt;
    expect_kind = kind;
    issue       = 1'b1;
    @(posedge clk);
    #5;
    issue       = 1'b0;
    expect_kind = kind_none;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < 100)
    begin
      @(posedge clk);
      #5;
      cycles++;
    end
    if (busy)
    begin
      errors++;
      $display("ERROR %s busy still high after 100 cycles", test_name);
    end
  endtask

  // Pulse and busy timing checks on every edge
  always @(posedge clk)
  begin
    if (reset)
    begin
      rv_due   <= 1'b0;
      br_due   <= 1'b0;
      div_due  <= 1'b0;
      busy_run <= 0;
    end
    else
    begin
      assert (result_valid === rv_due)
      else
      begin
        errors++;
        $display("FAIL %s result_valid expected %b actual %b", test_name, rv_due, result_valid);
      end
      assert (branch_valid === br_due)
      else
      begin
        errors++;
        $display("FAIL %s branch_valid expected %b actual %b", test_name, br_due, branch_valid);
      end
      if (div_due)
      begin
        assert (busy === 1'b1)
        else
        begin
          errors++;
          $display("ERROR %s busy did not rise after a divide issue", test_name);
        end
      end
      if (busy)
        busy_run <= busy_run + 1;
      else
      begin
        if (busy_run != 0)
        begin
          assert (busy_run == 33)
          else
          begin
            errors++;
            $display("FAIL %s busy cycles expected 33 actual %0d", test_name, busy_run);
          end
        end
        busy_run <= 0;
      end
      rv_due  <= issue && (expect_kind == kind_result);
      br_due  <= issue && (expect_kind == kind_branch);
      div_due <= issue && (expect_kind == kind_div);
    end
  end

  initial
  begin
    #(limit_ticks);
    $display("ERROR watchdog expired after %0d ns", limit_ticks);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    exec_instr_t ins;
    word_t       a;
    word_t       b;
    word_t       held;
    word_t       r;
    clk         = 1'b0;
    reset       = 1'b1;
    issue       = 1'b0;
    instr       = '0;
    rs_value    = '0;
    rt_value    = '0;
    expect_kind = kind_none;
    rng_state   = 32'h41248b99;
    model_hi    = '0;
    model_lo    = '0;
    checks      = 0;
    errors      = 0;
    rtype_fn = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_sll, fn_srl, fn_sra,
                 fn_sllv, fn_srlv, fn_srav, fn_slt, fn_sltu};
    itype_op = '{op_addiu, op_andi, op_ori, op_xori, op_lui, op_slti, op_sltiu, op_lb,
                 op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
    repeat (4) @(posedge clk);
    #5;
    reset = 1'b0;

    begin_test("reset_values");
    check_word("result", 32'h0, result);
    check_word("hi", 32'h0, hi);
    check_word("lo", 32'h0, lo);
    check_word("flags", 32'h0, {result_valid, branch_valid, branch_taken, busy});
    end_test();

    begin_test("rtype_alu");
    for (int i = 0; i < num_rtype; i++)
    begin
      r   = next_rand();
      ins = make_r(rtype_fn[r % 14], r[12:8]);
      a   = pick_operand();
      b   = pick_operand();
      issue_op(ins, a, b, kind_result);
      check_word("result", model_alu(ins, a, b), result);
    end
    end_test();

    begin_test("itype_alu");
    for (int i = 0; i < num_itype; i++)
    begin
      r   = next_rand();
      ins = make_i(itype_op[r % 15], r[31:16]);  // Upper bits give negative immediates too
      a   = pick_operand();
      issue_op(ins, a, next_rand(), kind_result);
      check_word("result", model_alu(ins, a, 32'h0), result);
    end
    end_test();

    begin_test("branches");
    for (int i = 0; i < num_branch; i++)
    begin
      r = next_rand();
      a = pick_operand();
      b = r[8] ? a : pick_operand();  // Equal operands half the time
      case (r % 6)
        0: ins = make_i(op_beq, r[31:16]);
        1: ins = make_i(op_bne, r[31:16]);
        default:
        begin
          ins        = make_i(op_regimm, r[31:16]);
          ins.rt_idx = (r % 6 == 2) ? 5'd0 : (r % 6 == 3) ? 5'd1 : (r % 6 == 4) ? 5'd16 : 5'd17;
        end
      endcase
      held = result;
      issue_op(ins, a, b, kind_branch);
      check_word("branch_taken", {31'b0, model_branch(ins, a, b)}, {31'b0, branch_taken});
      check_word("result held", held, result);
    end
    end_test();

    begin_test("multiply");
    for (int i = 0; i < num_mul; i++)
    begin
      case (i)
        0:
        begin
          a = 32'h8000_0000;
          b = 32'h8000_0000;
        end
        1:
        begin
          a = 32'hffff_ffff;
          b = 32'hffff_ffff;
        end
        2:
        begin
          a = 32'h8000_0000;
          b = 32'h7fff_ffff;
        end
        3:
        begin
          a = 32'h0;
          b = next_rand();
        end
        default:
        begin
          a = pick_operand();
          b = pick_operand();
        end
      endcase
      for (int s = 0; s < 2; s++)
      begin
        issue_op(make_r(s == 0 ? fn_mult : fn_multu, 5'd0), a, b, kind_none);
        model_mul(s == 0, a, b);
        check_word("busy", 32'h0, {31'b0, busy});
        check_word("hi", model_hi, hi);
        check_word("lo", model_lo, lo);
        issue_op(make_r(fn_mfhi, 5'd0), next_rand(), next_rand(), kind_result);
        check_word("mfhi", model_hi, result);
        issue_op(make_r(fn_mflo, 5'd0), next_rand(), next_rand(), kind_result);
        check_word("mflo", model_lo, result);
      end
    end
    end_test();

    begin_test("divide");
    for (int i = 0; i < num_div; i++)
    begin
      case (i)
        0:
        begin
          a = 32'h8000_0000;
          b = 32'hffff_ffff;
        end
        1:
        begin
          a = next_rand();
          b = 32'h0;
        end
        2:
        begin
          a = 32'h8000_0005;
          b = 32'h0;
        end
        default:
        begin
          a = pick_operand();
          b = next_rand() >> (next_rand() % 32);  // Spread of divisor sizes
        end
      endcase
      for (int s = 0; s < 2; s++)
      begin
        issue_op(make_r(s == 0 ? fn_div : fn_divu, 5'd0), a, b, kind_div);
        held = result;
        issue_op(make_r(fn_addu, 5'd0), next_rand(), next_rand(), kind_none);  // Dropped
        check_word("result during busy", held, result);
        wait_idle();
        model_div(s == 0, a, b);
        check_word("hi", model_hi, hi);
        check_word("lo", model_lo, lo);
      end
    end
    @(posedge clk);  // Lets the edge checks see the last busy fall
    #5;
    end_test();

    $display("Summary 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: mips_exec_top.f
source/mips_exec_pkg.sv
source/exec_control.sv
source/mips_alu.sv
source/branch_compare.sv
source/mul_div_unit.sv
source/mips_exec_top.sv
sim/mips_exec_tb.sv

// File: Bender.yml
package:
  name: mips_exec

sources:
  - source/mips_exec_pkg.sv
  - source/exec_control.sv
  - source/mips_alu.sv
  - source/branch_compare.sv
  - source/mul_div_unit.sv
  - source/mips_exec_top.sv
  - target: simulation
    files:
      - sim/mips_exec_tb.sv
